// ==== rtl/accumulator_unit.sv ====
// ==================================================
// 32-bit accumulator, load and add by bus write
// add wraps modulo 2^32, reads never change it
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module accumulator_unit (
   input  logic                 clk,
   input  logic                 reset,
   input  bridge_pkg::bus_req_t bus_req,
   input  logic                 handshake_1,
   output logic                 handshake_2,
   output bridge_pkg::word_t    rdata
);
   import bridge_pkg::*;

   word_t acc;
   word_t acc_next;
   logic  start;

   assign start = handshake_1 && !handshake_2;

   always_comb begin
      acc_next = acc;                        // read leaves it alone
      if (bus_req.write) begin
         if (bus_req.reg_address == `ACC_LOAD_ADDR)     acc_next = bus_req.wdata;
         else if (bus_req.reg_address == `ACC_ADD_ADDR) acc_next = acc + bus_req.wdata;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         handshake_2 <= 1'b0;
         acc         <= '0;
      end else begin
         handshake_2 <= handshake_1;
         if (start) acc <= acc_next;         // applied once per transaction
      end
   end

   always_ff @(posedge clk) begin
      if (start) rdata <= acc_next;          // post-write value
   end

endmodule

`default_nettype wire

// ==== rtl/bridge_defs.svh ====
// ==================================================
// packet lengths, status codes and bus address map
// bank base must be aligned to its depth
// ==================================================
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

`define REQ_BYTES      6       // cmd, address, four data bytes
`define RSP_BYTES      5       // status, four read bytes

`define CMD_WRITE_BIT  0       // cmd byte bit, 1 = bus write

`define STATUS_OK      8'h01   // address was mapped
`define STATUS_ERR     8'h80   // unmapped address

`define REG_BANK_BASE  8'h00   // first general register
`define REG_BANK_DEPTH 8       // number of general registers
`define ACC_LOAD_ADDR  8'h10   // write loads accumulator
`define ACC_ADD_ADDR   8'h11   // write adds to accumulator

`endif

// ==== rtl/bridge_pkg.sv ====
// ==================================================
// bus payload types shared by the bridge blocks
// ==================================================
`default_nettype none

package bridge_pkg;

   typedef logic [7:0]  byte_t;   // one uP byte
   typedef logic [31:0] word_t;   // one bus word

   // request from bridge to the fabric
   typedef struct packed {
      logic  write;         // 1 = bus write
      byte_t reg_address;   // register address
      word_t wdata;         // write data
   } bus_req_t;

   // response merged by the fabric
   typedef struct packed {
      logic  ok;            // 0 = unmapped address
      word_t rdata;         // read data or post-write value
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/bus_fabric.sv ====
// ==================================================
// steers bus handshake_1 to one target by address
// unmapped addresses answered here with ok low
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module bus_fabric (
   input  logic                 clk,
   input  logic                 reset,
   input  bridge_pkg::bus_req_t bus_req,
   input  logic                 bus_handshake_1,
   input  logic                 bank_handshake_2,
   input  bridge_pkg::word_t    bank_rdata,
   input  logic                 acc_handshake_2,
   input  bridge_pkg::word_t    acc_rdata,
   output logic                 bus_handshake_2,
   output bridge_pkg::bus_rsp_t bus_rsp,
   output logic                 bank_handshake_1,
   output logic                 acc_handshake_1
);
   import bridge_pkg::*;

   byte_t bank_offset;                       // address relative to bank base
   logic  sel_bank;
   logic  sel_acc;
   logic  sel_err;
   logic  err_handshake_2;

   assign bank_offset = bus_req.reg_address - `REG_BANK_BASE;
   assign sel_bank    = bank_offset < 8'(`REG_BANK_DEPTH);
   assign sel_acc     = (bus_req.reg_address == `ACC_LOAD_ADDR) ||
                        (bus_req.reg_address == `ACC_ADD_ADDR);
   assign sel_err     = !sel_bank && !sel_acc;

   assign bank_handshake_1 = bus_handshake_1 && sel_bank;
   assign acc_handshake_1  = bus_handshake_1 && sel_acc;

   // error responder follows handshake_1 one cycle late
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) err_handshake_2 <= 1'b0;
      else        err_handshake_2 <= bus_handshake_1 && sel_err;
   end

   // address stays put until the bridge takes a new request
   always_comb begin
      bus_rsp.ok = !sel_err;
      if (sel_bank) begin
         bus_handshake_2 = bank_handshake_2;
         bus_rsp.rdata   = bank_rdata;
      end else if (sel_acc) begin
         bus_handshake_2 = acc_handshake_2;
         bus_rsp.rdata   = acc_rdata;
      end else begin
         bus_handshake_2 = err_handshake_2;
         bus_rsp.rdata   = '0;               // zero word on error
      end
   end

endmodule

`default_nettype wire

// ==== rtl/reg_bank.sv ====
// ==================================================
// eight general registers, low address bits index
// write replies carry the new register value
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module reg_bank (
   input  logic                 clk,
   input  logic                 reset,
   input  bridge_pkg::bus_req_t bus_req,
   input  logic                 handshake_1,
   output logic                 handshake_2,
   output bridge_pkg::word_t    rdata
);
   import bridge_pkg::*;

   localparam int INDEX_BITS = $clog2(`REG_BANK_DEPTH);

   word_t                 regs [`REG_BANK_DEPTH];
   logic [INDEX_BITS-1:0] index;
   logic                  start;             // first cycle of handshake_1

   assign index = bus_req.reg_address[INDEX_BITS-1:0];
   assign start = handshake_1 && !handshake_2;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         handshake_2 <= 1'b0;
         for (int i = 0; i < `REG_BANK_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else begin
         handshake_2 <= handshake_1;         // rise and fall one cycle late
         if (start && bus_req.write) regs[index] <= bus_req.wdata;
      end
   end

   // response word registered with handshake_2
   always_ff @(posedge clk) begin
      if (start) rdata <= bus_req.write ? bus_req.wdata : regs[index];
   end

endmodule

`default_nettype wire

// ==== rtl/up_bridge_top.sv ====
// ==================================================
// uP byte port to internal bus, bank and accumulator
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module up_bridge_top (
   input  logic              clk,
   input  logic              reset,
   input  logic              up_start,
   input  logic              up_handshake_1,
   input  bridge_pkg::byte_t up_data_in,
   output logic              up_ack,
   output logic              up_handshake_2,
   output bridge_pkg::byte_t up_data_out
);
   import bridge_pkg::*;

   bus_req_t bus_req;
   bus_rsp_t bus_rsp;
   logic     bus_handshake_1;
   logic     bus_handshake_2;
   logic     bank_handshake_1;
   logic     bank_handshake_2;
   word_t    bank_rdata;
   logic     acc_handshake_1;
   logic     acc_handshake_2;
   word_t    acc_rdata;

   up_interface u_up_interface (
      .clk (clk), .reset (reset),
      .up_start (up_start), .up_handshake_1 (up_handshake_1), .up_data_in (up_data_in),
      .bus_handshake_2 (bus_handshake_2), .bus_rsp (bus_rsp),
      .up_ack (up_ack), .up_handshake_2 (up_handshake_2), .up_data_out (up_data_out),
      .bus_handshake_1 (bus_handshake_1), .bus_req (bus_req)
   );

   bus_fabric u_bus_fabric (
      .clk (clk), .reset (reset),
      .bus_req (bus_req), .bus_handshake_1 (bus_handshake_1),
      .bank_handshake_2 (bank_handshake_2), .bank_rdata (bank_rdata),
      .acc_handshake_2 (acc_handshake_2), .acc_rdata (acc_rdata),
      .bus_handshake_2 (bus_handshake_2), .bus_rsp (bus_rsp),
      .bank_handshake_1 (bank_handshake_1), .acc_handshake_1 (acc_handshake_1)
   );

   reg_bank u_reg_bank (
      .clk (clk), .reset (reset), .bus_req (bus_req),
      .handshake_1 (bank_handshake_1), .handshake_2 (bank_handshake_2), .rdata (bank_rdata)
   );

   accumulator_unit u_accumulator_unit (
      .clk (clk), .reset (reset), .bus_req (bus_req),
      .handshake_1 (acc_handshake_1), .handshake_2 (acc_handshake_2), .rdata (acc_rdata)
   );

endmodule

`default_nettype wire

// ==== rtl/up_interface.sv ====
// ==================================================
// uP byte packets to one 32-bit bus transaction
// reply byte valid only while up_handshake_2 is high
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module up_interface (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 up_start,
   input  logic                 up_handshake_1,
   input  bridge_pkg::byte_t    up_data_in,
   input  logic                 bus_handshake_2,
   input  bridge_pkg::bus_rsp_t bus_rsp,
   output logic                 up_ack,
   output logic                 up_handshake_2,
   output bridge_pkg::byte_t    up_data_out,
   output logic                 bus_handshake_1,
   output bridge_pkg::bus_req_t bus_req
);
   import bridge_pkg::*;

   logic       load_req_count;
   logic       load_rsp_count;
   logic       take_req_byte;
   logic       take_bus_rsp;
   logic       give_rsp_byte;
   logic       count_done;
   logic [2:0] byte_index;                   // request byte slot
   logic [2:0] remaining;                    // bytes left in packet

   byte_t req_packet [`REQ_BYTES];
   byte_t rsp_packet [`RSP_BYTES];

   up_interface_fsm u_fsm (
      .clk             (clk),
      .reset           (reset),
      .up_start        (up_start),
      .up_handshake_1  (up_handshake_1),
      .bus_handshake_2 (bus_handshake_2),
      .count_done      (count_done),
      .up_ack          (up_ack),
      .up_handshake_2  (up_handshake_2),
      .bus_handshake_1 (bus_handshake_1),
      .load_req_count  (load_req_count),
      .load_rsp_count  (load_rsp_count),
      .take_req_byte   (take_req_byte),
      .take_bus_rsp    (take_bus_rsp),
      .give_rsp_byte   (give_rsp_byte)
   );

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         byte_index <= '0;
         remaining  <= '0;
      end else if (load_req_count) begin
         byte_index <= '0;
         remaining  <= 3'(`REQ_BYTES);
      end else if (load_rsp_count) begin
         remaining  <= 3'(`RSP_BYTES);
      end else if (take_req_byte) begin
         byte_index <= byte_index + 3'd1;
         remaining  <= remaining - 3'd1;
      end else if (give_rsp_byte) begin
         remaining  <= remaining - 3'd1;
      end
   end

   assign count_done = (remaining == '0);

   always_ff @(posedge clk) begin
      if (take_req_byte) req_packet[byte_index] <= up_data_in;
   end

   // cmd, address, then data lsb first
   always_comb begin
      bus_req.write       = req_packet[0][`CMD_WRITE_BIT];
      bus_req.reg_address = req_packet[1];
      bus_req.wdata       = {req_packet[5], req_packet[4], req_packet[3], req_packet[2]};
   end

   // reply loads whole, then shifts toward slot 0
   always_ff @(posedge clk) begin
      if (take_bus_rsp) begin
         rsp_packet[0] <= bus_rsp.ok ? `STATUS_OK : `STATUS_ERR;
         for (int i = 0; i < 4; i++) begin
            rsp_packet[i+1] <= bus_rsp.rdata[8*i +: 8];   // lsb first
         end
      end else if (give_rsp_byte) begin
         up_data_out <= rsp_packet[0];
         for (int i = 0; i < `RSP_BYTES - 1; i++) begin
            rsp_packet[i] <= rsp_packet[i+1];
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/up_interface_fsm.sv ====
// ==================================================
// sequences uP byte handshakes and one bus handshake
// one transaction at a time, host paces every step
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module up_interface_fsm (
   input  logic clk,
   input  logic reset,
   input  logic up_start,
   input  logic up_handshake_1,
   input  logic bus_handshake_2,
   input  logic count_done,
   output logic up_ack,
   output logic up_handshake_2,
   output logic bus_handshake_1,
   output logic load_req_count,
   output logic load_rsp_count,
   output logic take_req_byte,
   output logic take_bus_rsp,
   output logic give_rsp_byte
);

   typedef enum logic [3:0] {
      S_IDLE,       // wait for up_start
      S_ACK,        // ack raised, arm request count
      S_REQ_WAIT,   // wait for request byte strobe
      S_REQ_DONE,   // wait for host to release byte
      S_BUS_REQ,    // bus handshake_1 high
      S_BUS_REL,    // wait for slave to drop handshake_2
      S_RSP_WAIT,   // wait for reply byte request
      S_RSP_DONE,   // wait for host to take byte
      S_FINISH      // wait for up_start low
   } state_t;

   state_t state;

   // strobes are decoded straight from state and inputs
   always_comb begin
      load_req_count = (state == S_ACK);
      take_req_byte  = (state == S_REQ_WAIT) && up_handshake_1;    // sample on hs2 rise
      take_bus_rsp   = (state == S_BUS_REQ)  && bus_handshake_2;   // capture on hs1 fall
      load_rsp_count = (state == S_BUS_REL)  && !bus_handshake_2;
      give_rsp_byte  = (state == S_RSP_WAIT) && up_handshake_1;    // byte out with hs2
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state           <= S_IDLE;
         up_ack          <= 1'b0;
         up_handshake_2  <= 1'b0;
         bus_handshake_1 <= 1'b0;
      end else begin
         case (state)
            S_IDLE: begin
               if (up_start) begin
                  up_ack <= 1'b1;                  // held for whole transaction
                  state  <= S_ACK;
               end
            end
            S_ACK: state <= S_REQ_WAIT;
            S_REQ_WAIT: begin
               if (up_handshake_1) begin
                  up_handshake_2 <= 1'b1;
                  state          <= S_REQ_DONE;
               end
            end
            S_REQ_DONE: begin
               if (!up_handshake_1) begin
                  up_handshake_2 <= 1'b0;
                  if (count_done) begin            // sixth byte in
                     bus_handshake_1 <= 1'b1;
                     state           <= S_BUS_REQ;
                  end else begin
                     state <= S_REQ_WAIT;
                  end
               end
            end
            S_BUS_REQ: begin
               if (bus_handshake_2) begin
                  bus_handshake_1 <= 1'b0;
                  state           <= S_BUS_REL;
               end
            end
            S_BUS_REL: begin
               if (!bus_handshake_2) state <= S_RSP_WAIT;
            end
            S_RSP_WAIT: begin
               if (up_handshake_1) begin
                  up_handshake_2 <= 1'b1;
                  state          <= S_RSP_DONE;
               end
            end
            S_RSP_DONE: begin
               if (!up_handshake_1) begin
                  up_handshake_2 <= 1'b0;
                  state          <= count_done ? S_FINISH : S_RSP_WAIT;
               end
            end
            S_FINISH: begin
               if (!up_start) begin
                  up_ack <= 1'b0;                  // marks end of transaction
                  state  <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_up_bridge -Mdir obj_dir -f tb.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build returned status $build_status"
   exit $build_status
fi

./obj_dir/Vtb_up_bridge
run_status=$?
if [ $run_status -ne 0 ]; then
   echo "simulation run returned status $run_status"
   exit $run_status
fi

exit 0

// ==== tb.f ====
+incdir+rtl
rtl/bridge_pkg.sv
rtl/up_interface_fsm.sv
rtl/up_interface.sv
rtl/bus_fabric.sv
rtl/reg_bank.sv
rtl/accumulator_unit.sv
rtl/up_bridge_top.sv
test/tb_up_bridge.sv

// ==== test/tb_up_bridge.sv ====
// ==================================================
// random host traffic against a register/acc model
// stops at the first mismatch or stuck handshake
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "bridge_defs.svh"

module tb_up_bridge;
   import bridge_pkg::*;

   localparam int INDEX_BITS      = $clog2(`REG_BANK_DEPTH);
   localparam int HANDSHAKE_LIMIT = 50;       // cycles a single handshake may take
   localparam int TIMEOUT_CYCLES  = 30000;    // ~245 transactions, at most ~100 cycles each

   logic  clk;
   logic  reset;
   logic  up_start;
   logic  up_handshake_1;
   byte_t up_data_in;
   logic  up_ack;
   logic  up_handshake_2;
   byte_t up_data_out;

   integer seed = 49;
   int     cycle_count = 0;
   word_t  model_regs [`REG_BANK_DEPTH];     // expected bank contents
   word_t  model_acc;                        // expected accumulator

   up_bridge_top DUT (
      .clk (clk), .reset (reset),
      .up_start (up_start), .up_handshake_1 (up_handshake_1), .up_data_in (up_data_in),
      .up_ack (up_ack), .up_handshake_2 (up_handshake_2), .up_data_out (up_data_out)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                // 40 ns period
   end

   task automatic stop_on_failure(input string line);
      $display("%s", line);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input word_t got, input word_t expected);
      if (got !== expected)
         stop_on_failure($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                   name, got, expected));
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES)
         stop_on_failure("run did not finish within the cycle limit");
   end

   function automatic word_t next_random();
      next_random = $random(seed);
   endfunction

   function automatic logic is_bank(input byte_t addr);
      int offset;
      offset  = int'(addr) - int'(`REG_BANK_BASE);
      is_bank = (offset >= 0) && (offset < `REG_BANK_DEPTH);   // inside the bank window
   endfunction

   function automatic byte_t unmapped_address();
      word_t r;
      r = next_random();
      while (is_bank(r[7:0]) || r[7:0] == `ACC_LOAD_ADDR || r[7:0] == `ACC_ADD_ADDR)
         r = next_random();
      return r[7:0];
   endfunction

   // 0 to 3 idle cycles, host side jitter
   task automatic host_delay();
      word_t r;
      r = next_random();
      repeat (r[1:0]) @(negedge clk);
   endtask

   // polls at falling edges, where DUT outputs are settled
   task automatic wait_for_level(input bit use_ack, input logic level, input string what);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = use_ack ? up_ack : up_handshake_2;
      while (seen !== level) begin
         if (cycles == HANDSHAKE_LIMIT) begin
            stop_on_failure($sformatf("%s did not go to %0b within %0d cycles",
                                      what, level, HANDSHAKE_LIMIT));
         end else begin
            @(negedge clk);
            cycles++;
            seen = use_ack ? up_ack : up_handshake_2;
         end
      end
   endtask

   // one full packet exchange, six bytes out, five back
   task automatic host_transaction(input byte_t cmd, input byte_t addr, input word_t wdata,
                                   output byte_t status, output word_t rdata);
      byte_t req [`REQ_BYTES];
      byte_t rsp [`RSP_BYTES];
      int    i;
      req[0] = cmd;
      req[1] = addr;
      for (i = 0; i < 4; i++) req[i+2] = wdata[8*i +: 8];   // lsb first
      host_delay();
      up_start = 1'b1;
      wait_for_level(1'b1, 1'b1, "up_ack");
      for (i = 0; i < `REQ_BYTES; i++) begin
         host_delay();
         up_data_in     = req[i];
         up_handshake_1 = 1'b1;
         wait_for_level(1'b0, 1'b1, "up_handshake_2 (request byte)");
         host_delay();
         up_handshake_1 = 1'b0;
         wait_for_level(1'b0, 1'b0, "up_handshake_2 (request byte)");
      end
      for (i = 0; i < `RSP_BYTES; i++) begin
         host_delay();
         up_handshake_1 = 1'b1;
         wait_for_level(1'b0, 1'b1, "up_handshake_2 (reply byte)");
         rsp[i] = up_data_out;                 // valid while hs2 high
         host_delay();
         up_handshake_1 = 1'b0;
         wait_for_level(1'b0, 1'b0, "up_handshake_2 (reply byte)");
      end
      check_value("up_ack", 32'(up_ack), 32'h1);   // held until start drops
      host_delay();
      up_start = 1'b0;
      wait_for_level(1'b1, 1'b0, "up_ack");
      status = rsp[0];
      rdata  = {rsp[4], rsp[3], rsp[2], rsp[1]};
   endtask

   // expected reply from the address map rules, updates model state
   task automatic model_apply(input logic write, input byte_t addr, input word_t wdata,
                              output byte_t status, output word_t rdata);
      byte_t offset;
      offset = addr - `REG_BANK_BASE;
      status = `STATUS_OK;
      if (is_bank(addr)) begin
         if (write) model_regs[offset[INDEX_BITS-1:0]] = wdata;
         rdata = model_regs[offset[INDEX_BITS-1:0]];
      end else if (addr == `ACC_LOAD_ADDR) begin
         if (write) model_acc = wdata;
         rdata = model_acc;
      end else if (addr == `ACC_ADD_ADDR) begin
         if (write) model_acc = model_acc + wdata;   // wraps mod 2^32
         rdata = model_acc;
      end else begin
         status = `STATUS_ERR;
         rdata  = '0;
      end
   endtask

   task automatic exchange(input byte_t cmd, input byte_t addr, input word_t wdata);
      byte_t got_status;
      word_t got_rdata;
      byte_t exp_status;
      word_t exp_rdata;
      host_transaction(cmd, addr, wdata, got_status, got_rdata);
      model_apply(cmd[`CMD_WRITE_BIT], addr, wdata, exp_status, exp_rdata);
      check_value($sformatf("status byte @0x%02h", addr), 32'(got_status), 32'(exp_status));
      check_value($sformatf("read word @0x%02h", addr), got_rdata, exp_rdata);
   endtask

   initial begin
      word_t r;
      byte_t addr;
      int    i;
      reset          = 1'b0;
      up_start       = 1'b0;
      up_handshake_1 = 1'b0;
      up_data_in     = '0;
      model_acc      = '0;
      for (i = 0; i < `REG_BANK_DEPTH; i++) model_regs[i] = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      check_value("up_ack", 32'(up_ack), 32'h0);
      check_value("up_handshake_2", 32'(up_handshake_2), 32'h0);
      // bank write then readback
      for (i = 0; i < `REG_BANK_DEPTH; i++) exchange(8'h01, 8'(i), next_random());
      for (i = 0; i < `REG_BANK_DEPTH; i++) exchange(8'h00, 8'(i), next_random());
      // accumulator load, running adds, reads of both addresses
      exchange(8'h01, `ACC_LOAD_ADDR, next_random());
      repeat (6) exchange(8'h01, `ACC_ADD_ADDR, next_random());
      exchange(8'h00, `ACC_LOAD_ADDR, next_random());
      exchange(8'h00, `ACC_ADD_ADDR, next_random());
      exchange(8'h00, `ACC_LOAD_ADDR, next_random());
      // unmapped traffic, then confirm nothing moved
      repeat (10) begin
         r = next_random();
         exchange(r[7:0], unmapped_address(), next_random());
      end
      for (i = 0; i < `REG_BANK_DEPTH; i++) exchange(8'h00, 8'(i), next_random());
      exchange(8'h00, `ACC_ADD_ADDR, next_random());
      // mixed random traffic
      repeat (200) begin
         r = next_random();
         case (r[9:8])
            2'd0, 2'd1: addr = `REG_BANK_BASE + 8'(r[INDEX_BITS-1:0]);
            2'd2:       addr = r[4] ? `ACC_ADD_ADDR : `ACC_LOAD_ADDR;
            default:    addr = r[23:16];   // any address, mapped or not
         endcase
         exchange(r[31:24], addr, next_random());
      end
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire
